/* hdl/pipePkg.sv */
package pipePkg;

    localparam int XLEN = 32;
    localparam int IdxW = 5;   // register index width.

    typedef enum logic [5:0] {
        opRtype    = 6'h00,
        opAddi     = 6'h08,
        opOri      = 6'h0d,
        opLui      = 6'h0f,
        opSpecial2 = 6'h1c   // holds mul.
    } opcode_e;

    typedef enum logic [5:0] {
        fnMul = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui, aluMul
    } aluOp_e;

    typedef struct packed {
        opcode_e         opcode;
        logic [IdxW-1:0] rs;
        logic [IdxW-1:0] rt;
        logic [IdxW-1:0] rd;
        logic [4:0]      shamt;
        funct_e          funct;
    } rFmt_t;

    typedef struct packed {
        opcode_e         opcode;
        logic [IdxW-1:0] rs;
        logic [IdxW-1:0] rt;
        logic [15:0]     imm;
    } iFmt_t;

    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instrWord_u;

    typedef struct packed {
        logic       valid;
        instrWord_u word;
    } fetch_t;

    typedef struct packed {
        logic            valid;
        aluOp_e          op;
        logic [IdxW-1:0] rs;
        logic [IdxW-1:0] rt;
        logic            useRs;
        logic            useRt;   // low selects the immediate as operand b.
        logic [IdxW-1:0] rd;
        logic            wr;
        logic [XLEN-1:0] imm;
        logic            mul;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [IdxW-1:0] rd;
        logic            wr;
        logic            mul;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] srcA;
        logic [XLEN-1:0] srcB;
    } exec_t;

    typedef struct packed {
        logic            valid;
        logic [IdxW-1:0] rd;
        logic [XLEN-1:0] value;
    } retire_t;

endpackage

/* hdl/pipeRegs.sv */
module decodeReg (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                flush,
    input  pipePkg::fetch_t [1:0] in,
    output pipePkg::fetch_t [1:0] out
);
    import pipePkg::*;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            out <= '0;
        end
        else if (flush)
        begin
            out <= '0;   // the incoming pair is dropped too.
        end
        else if (!stall)
        begin
            out <= in;
        end
    end

endmodule

module commitReg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  pipePkg::exec_t [1:0] in,
    output pipePkg::exec_t [1:0] out,
    output logic                 firstCycle
);
    import pipePkg::*;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            out        <= '0;
            firstCycle <= 1'b1;
        end
        else if (flush)
        begin
            out        <= '0;
            firstCycle <= 1'b1;
        end
        else if (!stall)
        begin
            out        <= in;
            firstCycle <= 1'b1;
        end
        else
        begin
            firstCycle <= 1'b0;   // second cycle of a held operation.
        end
    end

endmodule

module retireReg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  pipePkg::exec_t [1:0] in,
    output pipePkg::exec_t [1:0] out
);
    import pipePkg::*;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            out <= '0;
        end
        else if (flush)
        begin
            out <= '0;   // bubble while C holds a mul.
        end
        else if (!stall)
        begin
            out <= in;
        end
    end

endmodule

/* hdl/issueUnit.sv */
module issueUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stallC,
    input  pipePkg::fetch_t   [1:0] fetched,
    output pipePkg::decoded_t [1:0] issued,
    output logic                    splitHold
);
    import pipePkg::*;

    decoded_t [1:0] dec;
    logic           dep;
    logic           pending;   // slot 1 of a split pair goes next.

    function automatic decoded_t decode(fetch_t f);
        decoded_t d;
        d       = '0;
        d.valid = f.valid;
        d.rs    = f.word.rFmt.rs;
        d.rt    = f.word.rFmt.rt;
        case (f.word.rFmt.opcode)
            opRtype:
            begin
                d.rd    = f.word.rFmt.rd;
                d.useRs = 1'b1;
                d.useRt = 1'b1;
                d.wr    = 1'b1;
                case (f.word.rFmt.funct)
                    fnAdd:   d.op = aluAdd;
                    fnSub:   d.op = aluSub;
                    fnAnd:   d.op = aluAnd;
                    fnOr:    d.op = aluOr;
                    fnXor:   d.op = aluXor;
                    fnSlt:   d.op = aluSlt;
                    default: d.wr = 1'b0;   // unsupported, runs as a no-op.
                endcase
            end
            opSpecial2:
            begin
                d.rd    = f.word.rFmt.rd;
                d.useRs = 1'b1;
                d.useRt = 1'b1;
                d.op    = aluMul;
                d.mul   = (f.word.rFmt.funct == fnMul);
                d.wr    = d.mul;
            end
            opAddi:
            begin
                d.op    = aluAdd;
                d.rd    = f.word.iFmt.rt;
                d.useRs = 1'b1;
                d.wr    = 1'b1;
                d.imm   = {{16{f.word.iFmt.imm[15]}}, f.word.iFmt.imm};
            end
            opOri:
            begin
                d.op    = aluOr;
                d.rd    = f.word.iFmt.rt;
                d.useRs = 1'b1;
                d.wr    = 1'b1;
                d.imm   = {16'h0000, f.word.iFmt.imm};
            end
            opLui:
            begin
                d.op  = aluLui;
                d.rd  = f.word.iFmt.rt;
                d.wr  = 1'b1;
                d.imm = {f.word.iFmt.imm, 16'h0000};
            end
            default: d.wr = 1'b0;
        endcase
        return d;
    endfunction

    assign dec[0] = decode(fetched[0]);
    assign dec[1] = decode(fetched[1]);

    // slot 1 reads what slot 0 writes.
    assign dep = dec[0].valid && dec[0].wr && (dec[0].rd != '0) && dec[1].valid &&
                 ((dec[1].useRs && (dec[1].rs == dec[0].rd)) ||
                  (dec[1].useRt && (dec[1].rt == dec[0].rd)));

    assign splitHold = dep && !pending;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            pending <= 1'b0;
        else if (!stallC)
            pending <= splitHold;
    end

    always_comb
    begin
        issued = dec;
        if (splitHold)
            issued[1] = '0;   // older half first.
        else if (pending)
            issued[0] = '0;
    end

endmodule

/* hdl/execUnit.sv */
module execUnit (
    input  pipePkg::decoded_t [1:0]                    issued,
    output logic              [3:0][pipePkg::IdxW-1:0] rdIdx,
    input  logic              [3:0][pipePkg::XLEN-1:0] rdData,
    input  pipePkg::exec_t    [1:0]                    commitFwd,
    input  pipePkg::exec_t    [1:0]                    retireFwd,
    output pipePkg::exec_t    [1:0]                    execOut
);
    import pipePkg::*;

    function automatic logic hit(exec_t e, logic [IdxW-1:0] idx);
        return e.valid && e.wr && (e.rd == idx) && (idx != '0);
    endfunction

    // later matches override earlier ones, so C slot 1 ends up youngest.
    function automatic logic [XLEN-1:0] forward(logic [IdxW-1:0] idx,
                                                logic [XLEN-1:0] rfVal,
                                                exec_t [1:0] cFwd,
                                                exec_t [1:0] rFwd);
        logic [XLEN-1:0] val;
        val = rfVal;
        for (int s = 0; s < 2; s++)
            if (hit(rFwd[s], idx))
                val = rFwd[s].result;
        for (int s = 0; s < 2; s++)
            if (hit(cFwd[s], idx) && !cFwd[s].mul)   // pending product is not ready.
                val = cFwd[s].result;
        return val;
    endfunction

    assign rdIdx = {issued[1].rt, issued[1].rs, issued[0].rt, issued[0].rs};

    always_comb
    begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        execOut = '0;
        for (int i = 0; i < 2; i++)
        begin
            a = forward(issued[i].rs, rdData[2*i], commitFwd, retireFwd);
            b = issued[i].useRt ? forward(issued[i].rt, rdData[2*i+1], commitFwd, retireFwd)
                                : issued[i].imm;
            execOut[i].valid = issued[i].valid;
            execOut[i].rd    = issued[i].rd;
            execOut[i].wr    = issued[i].wr;
            execOut[i].mul   = issued[i].mul;
            execOut[i].srcA  = a;
            execOut[i].srcB  = b;
            case (issued[i].op)
                aluAdd:  execOut[i].result = a + b;
                aluSub:  execOut[i].result = a - b;
                aluAnd:  execOut[i].result = a & b;
                aluOr:   execOut[i].result = a | b;
                aluXor:  execOut[i].result = a ^ b;
                aluSlt:  execOut[i].result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                aluLui:  execOut[i].result = b;
                default: execOut[i].result = '0;   // mul finishes in C.
            endcase
        end
    end

endmodule

/* hdl/commitStage.sv */
module commitStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  pipePkg::exec_t [1:0] in,
    output pipePkg::exec_t [1:0] out,
    output logic                 firstCycle
);
    import pipePkg::*;

    localparam int Half = XLEN / 2;

    exec_t [1:0]                held;
    logic  [1:0][XLEN-1:0]      pLL;
    logic  [1:0][Half-1:0]      pLH;   // only the low half reaches the result.
    logic  [1:0][Half-1:0]      pHL;

    commitReg commitReg_inst (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .in         (in),
        .out        (held),
        .firstCycle (firstCycle)
    );

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (firstCycle && held[i].valid && held[i].mul)
            begin
                pLL[i] <= held[i].srcA[Half-1:0] * held[i].srcB[Half-1:0];
                pLH[i] <= held[i].srcA[Half-1:0] * held[i].srcB[XLEN-1:Half];
                pHL[i] <= held[i].srcA[XLEN-1:Half] * held[i].srcB[Half-1:0];
            end
        end
    end

    always_comb
    begin
        out = held;
        for (int i = 0; i < 2; i++)
        begin
            if (held[i].mul)
            begin
                out[i].mul    = firstCycle;   // flag stays up until the sum is valid.
                out[i].result = pLL[i] + {pLH[i] + pHL[i], {Half{1'b0}}};
            end
        end
    end

endmodule

/* hdl/regFile.sv */
module regFile #(
    parameter int NumRegs = 32
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic             [3:0][pipePkg::IdxW-1:0] rdIdx,
    output logic             [3:0][pipePkg::XLEN-1:0] rdData,
    input  pipePkg::retire_t [1:0]                    wr
);
    import pipePkg::*;

    logic [XLEN-1:0] regs [NumRegs];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int r = 0; r < NumRegs; r++)
                regs[r] <= '0;
        end
        else
        begin
            for (int w = 0; w < 2; w++)   // slot 1 written last and wins.
                if (wr[w].valid && (wr[w].rd != '0))
                    regs[wr[w].rd] <= wr[w].value;
        end
    end

    always_comb
    begin
        for (int p = 0; p < 4; p++)
        begin
            rdData[p] = regs[rdIdx[p]];
            for (int w = 0; w < 2; w++)
                if (wr[w].valid && (wr[w].rd == rdIdx[p]))
                    rdData[p] = wr[w].value;   // write-through.
            if (rdIdx[p] == '0)
                rdData[p] = '0;
        end
    end

endmodule

/* hdl/hazardCtrl.sv */
module hazardCtrl (
    input  pipePkg::exec_t [1:0] commitOut,
    input  logic                 firstCycle,
    input  logic                 splitHold,
    input  logic                 redirect,
    output logic                 stallD,
    output logic                 flushD,
    output logic                 stallC,
    output logic                 flushR,
    output logic                 fetchReady
);
    import pipePkg::*;

    logic mulInC;

    assign mulInC = (commitOut[0].valid && commitOut[0].mul) ||
                    (commitOut[1].valid && commitOut[1].mul);

    // the product needs one more cycle in C.
    assign stallC = mulInC && firstCycle;

    assign flushR = stallC;   // nothing leaves C this cycle.

    // a split only holds D, C keeps moving.
    assign stallD = stallC || splitHold;

    assign fetchReady = !stallD;

    assign flushD = redirect && !stallD;

endmodule

/* hdl/dualPipe.sv */
module dualPipe #(
    parameter int NumRegs = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  pipePkg::fetch_t  [1:0] fetchIn,
    input  logic                   redirect,
    output logic                   fetchReady,
    output pipePkg::retire_t [1:0] retire
);
    import pipePkg::*;

    fetch_t   [1:0]           decOut;
    decoded_t [1:0]           issued;
    exec_t    [1:0]           execOut;
    exec_t    [1:0]           commitOut;
    exec_t    [1:0]           retireOut;
    logic     [3:0][IdxW-1:0] rdIdx;
    logic     [3:0][XLEN-1:0] rdData;
    logic                     stallD;
    logic                     flushD;
    logic                     stallC;
    logic                     flushR;
    logic                     firstCycle;
    logic                     splitHold;

    decodeReg decodeReg_inst (
        .clk   (clk),
        .reset (reset),
        .stall (stallD),
        .flush (flushD),
        .in    (fetchIn),
        .out   (decOut)
    );

    issueUnit issueUnit_inst (
        .clk       (clk),
        .reset     (reset),
        .stallC    (stallC),
        .fetched   (decOut),
        .issued    (issued),
        .splitHold (splitHold)
    );

    execUnit execUnit_inst (
        .issued    (issued),
        .rdIdx     (rdIdx),
        .rdData    (rdData),
        .commitFwd (commitOut),
        .retireFwd (retireOut),
        .execOut   (execOut)
    );

    // redirect also squashes the pair leaving D.
    commitStage commitStage_inst (
        .clk        (clk),
        .reset      (reset),
        .stall      (stallC),
        .flush      (flushD),
        .in         (execOut),
        .out        (commitOut),
        .firstCycle (firstCycle)
    );

    retireReg retireReg_inst (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (flushR),
        .in    (commitOut),
        .out   (retireOut)
    );

    regFile #(
        .NumRegs (NumRegs)
    ) regFile_inst (
        .clk    (clk),
        .reset  (reset),
        .rdIdx  (rdIdx),
        .rdData (rdData),
        .wr     (retire)
    );

    hazardCtrl hazardCtrl_inst (
        .commitOut  (commitOut),
        .firstCycle (firstCycle),
        .splitHold  (splitHold),
        .redirect   (redirect),
        .stallD     (stallD),
        .flushD     (flushD),
        .stallC     (stallC),
        .flushR     (flushR),
        .fetchReady (fetchReady)
    );

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            retire[i].valid = retireOut[i].valid && retireOut[i].wr;
            retire[i].rd    = retireOut[i].rd;
            retire[i].value = retireOut[i].result;
        end
    end

endmodule

/* test/dualPipe_sva.sv */
module dualPipeSva (
    input logic                   clk,
    input logic                   reset,
    input logic                   stallC,
    input logic                   fetchReady,
    input logic                   firstCycle,
    input pipePkg::fetch_t  [1:0] decOut,
    input pipePkg::retire_t [1:0] retire
);
    timeunit 1ns;
    timeprecision 100ps;

    import pipePkg::*;

    int failures = 0;

    // a pair that is not taken leaves D as it was.
    heldWhileNotReady: assert property (@(posedge clk) disable iff (reset)
        !fetchReady |=> $stable(decOut))
    else
    begin
        $error("D changed while fetchReady was low");
        failures++;
    end

    secondCycle: assert property (@(posedge clk) disable iff (reset)
        stallC |=> !firstCycle)
    else
    begin
        $error("firstCycle still high after a stalled mul");
        failures++;
    end

    quietInReset: assert property (@(posedge clk)
        reset |-> (!retire[0].valid && !retire[1].valid))
    else
    begin
        $error("retire valid during reset");
        failures++;
    end

endmodule

bind dualPipe dualPipeSva dualPipeSva_inst (
    .clk        (clk),
    .reset      (reset),
    .stallC     (stallC),
    .fetchReady (fetchReady),
    .firstCycle (firstCycle),
    .decOut     (decOut),
    .retire     (retire)
);

/* test/dualPipeTb.sv */
module dualPipeTb;
    timeunit 1ns;
    timeprecision 100ps;

    import pipePkg::*;

    localparam int CaseWords   = 10;   // words per line of the cases file.
    localparam int MaxCases    = 32;
    localparam int DrainCycles = 8;

    typedef struct packed {
        logic [7:0]      caseIdx;
        logic [IdxW-1:0] rd;
        logic [XLEN-1:0] value;
    } expect_t;

    logic             clk;
    logic             reset;
    fetch_t  [1:0]    fetchIn;
    logic             redirect;
    logic             fetchReady;
    retire_t [1:0]    retire;

    logic [31:0]      caseMem [MaxCases*CaseWords];
    expect_t          expQ [$];

    int               numCases;
    int               nextCase;
    int               curCase;
    int               errors;
    int               checked;
    int               cycles;
    int               limit;
    int               drain;
    int               stallCycles;
    int               expStalls;
    bit               lastTaken;
    bit               timedOut;
    bit               finished;

    dualPipe #(
        .NumRegs (32)
    ) dualPipe_inst (
        .clk        (clk),
        .reset      (reset),
        .fetchIn    (fetchIn),
        .redirect   (redirect),
        .fetchReady (fetchReady),
        .retire     (retire)
    );

    always #2 clk = ~clk;

    task automatic loadCases;
        for (int i = 0; i < MaxCases*CaseWords; i++)
            caseMem[i] = '1;   // all ones marks the end of the list.
        $readmemh("test/pipe_cases.txt", caseMem);
        numCases = 0;
        while (numCases < MaxCases && caseMem[numCases*CaseWords] !== '1)
            numCases++;
    endtask

    // MIPS encodings, zero when the word writes no register.
    function automatic logic [4:0] destOf(logic [31:0] w);
        logic [5:0] opc;
        logic [5:0] fn;
        opc = w[31:26];
        fn  = w[5:0];
        if (opc == 6'h00 && fn inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a})
            return w[15:11];
        if (opc == 6'h1c && fn == 6'h02)
            return w[15:11];
        if (opc inside {6'h08, 6'h0d, 6'h0f})
            return w[20:16];
        return 5'd0;
    endfunction

    function automatic bit readsReg(logic [31:0] w, logic [4:0] r);
        logic [5:0] opc;
        opc = w[31:26];
        if (opc == 6'h00 || opc == 6'h1c)
            return (w[25:21] == r) || (w[20:16] == r);
        if (opc == 6'h08 || opc == 6'h0d)
            return w[25:21] == r;
        return 1'b0;
    endfunction

    function automatic bit isMul(logic [31:0] w);
        return (w[31:26] == 6'h1c) && (w[5:0] == 6'h02);
    endfunction

    // fetch cycles a case costs for a split and for a mul.
    function automatic int stallsFor(int idx);
        int          base;
        logic [31:0] w0;
        logic [31:0] w1;
        logic        v0;
        logic        v1;
        int          n;
        base = idx * CaseWords;
        v0   = caseMem[base][0];
        w0   = caseMem[base+1];
        v1   = caseMem[base+2][0];
        w1   = caseMem[base+3];
        n    = 0;
        if (caseMem[base+4][0])
            return 0;   // dropped before it reaches D.
        if (v0 && v1 && destOf(w0) != 5'd0 && readsReg(w1, destOf(w0)))
            n++;
        if ((v0 && isMul(w0)) || (v1 && isMul(w1)))
            n++;
        return n;
    endfunction

    // put the next pair on the fetch port, or bubbles once the list is done.
    task automatic presentNext;
        int base;
        if (nextCase < numCases)
        begin
            base             = nextCase * CaseWords;
            fetchIn[0].valid = caseMem[base][0];
            fetchIn[0].word  = caseMem[base+1];
            fetchIn[1].valid = caseMem[base+2][0];
            fetchIn[1].word  = caseMem[base+3];
            redirect         = caseMem[base+4][0];
            curCase          = nextCase;
            nextCase++;
        end
        else
        begin
            fetchIn  = '0;
            redirect = 1'b0;
            curCase  = -1;
        end
    endtask

    task automatic pushExpected(input int idx);
        int      base;
        int      n;
        expect_t e;
        base = idx * CaseWords;
        n    = caseMem[base+5];
        for (int k = 0; k < n; k++)
        begin
            e.caseIdx = idx[7:0];
            e.rd      = caseMem[base+6+2*k][IdxW-1:0];
            e.value   = caseMem[base+7+2*k];
            expQ.push_back(e);
        end
    endtask

    task automatic checkRetire;
        expect_t e;
        for (int s = 0; s < 2; s++)
        begin
            if (retire[s].valid)
            begin
                if (expQ.size() == 0)
                begin
                    errors++;
                    $display("Error at %0t: unexpected retire in slot %0d, rd %0d value %h",
                             $time, s, retire[s].rd, retire[s].value);
                end
                else
                begin
                    e = expQ.pop_front();
                    checked++;
                    if (retire[s].rd !== e.rd || retire[s].value !== e.value)
                    begin
                        errors++;
                        $display("Error at %0t: case %0d slot %0d got r%0d=%h, expected r%0d=%h",
                                 $time, e.caseIdx, s, retire[s].rd, retire[s].value,
                                 e.rd, e.value);
                    end
                end
            end
        end
    endtask

    task automatic reportMissing;
        $display("Timeout after %0d cycles, %0d retire records still outstanding",
                 cycles, expQ.size());
        foreach (expQ[i])
            $display("Case %0d never retired its write to register %0d",
                     expQ[i].caseIdx, expQ[i].rd);
        if (nextCase < numCases)
            $display("Cases %0d to %0d were never fetched", nextCase, numCases - 1);
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        fetchIn     = '0;
        redirect    = 1'b0;
        errors      = 0;
        checked     = 0;
        cycles      = 0;
        drain       = 0;
        stallCycles = 0;
        expStalls   = 0;
        timedOut    = 1'b0;
        finished    = 1'b0;
        curCase     = -1;
        nextCase    = 0;
        lastTaken   = 1'b1;
        loadCases();
        if (numCases == 0)
        begin
            errors++;
            $display("No cases could be read from test/pipe_cases.txt");
        end
        limit = numCases * 6 + 40;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (!finished && !timedOut)
        begin
            @(negedge clk);
            cycles++;
            checkRetire();
            if (lastTaken)
                presentNext();
            // fetchReady does not depend on the fetch inputs.
            lastTaken = fetchReady;
            if (!fetchReady)
                stallCycles++;
            if (fetchReady && curCase >= 0)
            begin
                pushExpected(curCase);
                expStalls += stallsFor(curCase);
            end
            if (curCase < 0 && nextCase >= numCases && expQ.size() == 0)
                drain++;
            if (drain >= DrainCycles)
                finished = 1'b1;
            if (cycles >= limit)
                timedOut = 1'b1;
        end

        if (timedOut)
        begin
            reportMissing();
            errors++;
        end
        else if (stallCycles != expStalls)
        begin
            errors++;
            $display("Error at %0t: fetchReady low for %0d cycles, expected %0d",
                     $time, stallCycles, expStalls);
        end
        errors += dualPipe_inst.dualPipeSva_inst.failures;
        $display("Checked %0d retire records, %0d errors", checked, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* test/pipe_cases.txt */
// v0 word0 v1 word1 redirect count rd0 value0 rd1 value1
// expected records are in program order, count says how many are used
// independent alu and immediate ops
1 20010005 1 2002fffd 0 2 01 00000005 02 fffffffd
1 3c031234 1 34048001 0 2 03 12340000 04 00008001
// forwarding from C and R
1 00232820 1 00823022 0 2 05 12340005 06 00008004
1 0041382a 1 0022402a 0 2 07 00000001 08 00000000
1 00a64824 1 00a45026 0 2 09 00000004 0a 12348004
// register 0 writes retire but read back as zero
1 20200007 1 00015825 0 2 00 0000000c 0b 00000005
1 00016020 1 340d00ff 0 2 0c 00000005 0d 000000ff
// split pair
1 202e000a 1 01cd7820 0 2 0e 0000000f 0f 0000010e
// both slots write r16, slot 1 wins
1 20100011 1 34100022 0 2 10 00000011 10 00000022
1 02008820 1 02109020 0 2 11 00000022 12 00000044
// mul and its consumers
1 71429802 1 22140001 0 2 13 c9627ff4 14 00000023
1 0261a820 1 0293b026 0 2 15 c9627ff9 16 c9627fd7
1 702cb802 1 02e1c020 0 2 17 00000019 18 0000001e
// pair in D is squashed by the redirect, then the redirect pair is dropped
1 20190055 1 201a0066 0 0 00 00000000 00 00000000
1 20190077 1 201a0088 1 0 00 00000000 00 00000000
1 0321d820 1 0341e020 0 2 1b 00000005 1c 00000005
// bubble in slot 0
0 00000000 1 0250e822 0 1 1d 00000022 00 00000000
1 0200f020 1 037cf820 0 2 1e 00000022 1f 0000000a

/* sources.f */
hdl/pipePkg.sv
hdl/pipeRegs.sv
hdl/issueUnit.sv
hdl/execUnit.sv
hdl/commitStage.sv
hdl/regFile.sv
hdl/hazardCtrl.sv
hdl/dualPipe.sv
test/dualPipe_sva.sv
test/dualPipeTb.sv

/* Bender.yml */
package:
  name: dual_pipe

sources:
  - files:
      - hdl/pipePkg.sv
      - hdl/pipeRegs.sv
      - hdl/issueUnit.sv
      - hdl/execUnit.sv
      - hdl/commitStage.sv
      - hdl/regFile.sv
      - hdl/hazardCtrl.sv
      - hdl/dualPipe.sv
  - target: test
    files:
      - test/dualPipe_sva.sv
      - test/dualPipeTb.sv
